// File: design/aluPkg.sv
package aluPkg;

  //////////////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////////////

  localparam int XLEN    = 32;               // Operand width, RV32 only
  localparam int TAG_W   = 4;                // Request tag echoed on the response
  localparam int SHAMT_W = $clog2(XLEN);     // Shift amount and bit index
  localparam int CNT_W   = $clog2(XLEN + 1); // cpop result, 0 to 32

  // Every operation the stage decodes
  typedef enum logic [4:0] {
    opAdd, opSub, opSll, opSlt, opSltu, opXor, opSrl, opSra, opOr, opAnd, // RV32I
    opSh1add, opSh2add, opSh3add,                                          // Zba
    opAndn, opOrn, opXnor, opRol, opRor,                                   // Zbb logic, rotate
    opMin, opMax, opMinu, opMaxu, opCpop,                                  // Zbb compare, count
    opBset, opBclr, opBinv, opBext,                                        // Zbs
    opIllegal
  } aluOpE;

  // Source of the ALU result
  typedef enum logic [2:0] {
    selSum, selShift, selSlt, selSltu, selXor, selOr, selAnd, selBitManip
  } resultSelE;

  // Operations inside the bit-manipulation unit
  typedef enum logic [3:0] {
    bmMin, bmMax, bmMinu, bmMaxu, bmCpop, bmBset, bmBclr, bmBinv, bmBext
  } bitManipOpE;

  //////////////////////////////////////////////////////////////////////////////
  // Bundles
  //////////////////////////////////////////////////////////////////////////////

  // Decoder to ALU, 13 bits
  typedef struct packed {
    logic       subArith;  // Subtract, or arithmetic right shift
    logic       invB;      // andn, orn, xnor
    logic [1:0] shAddAmt;  // Pre-shift of A for shNadd
    logic       right;     // Shift direction
    logic       rotate;    // Rotate instead of shift
    resultSelE  resultSel;
    bitManipOpE bmOp;
  } aluCtrlT;

  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic             aluOp;   // 0 means address add
    logic [6:0]       funct7;
    logic [2:0]       funct3;
    logic [XLEN-1:0]  a;
    logic [XLEN-1:0]  b;
  } execReqT;

  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic             illegal; // Unknown encoding, result is zero
    logic [XLEN-1:0]  result;
  } execRspT;

endpackage

// File: design/aluDecoder.sv
`timescale 1ns/1ns

module aluDecoder import aluPkg::*; (
  input  logic       aluOp,   // 0 forces an address add
  input  logic [6:0] funct7,
  input  logic [2:0] funct3,
  output aluCtrlT    ctrl,
  output logic       illegal
);

  aluOpE op;  // Decoded operation

  //////////////////////////////////////////////////////////////////////////////
  // Encoding match
  //////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (!aluOp) begin
      op = opAdd;                              // Address generation, funct ignored
    end else begin
      case ({funct7, funct3})
        10'b0000000_000: op = opAdd;
        10'b0100000_000: op = opSub;
        10'b0000000_001: op = opSll;
        10'b0000000_010: op = opSlt;
        10'b0000000_011: op = opSltu;
        10'b0000000_100: op = opXor;
        10'b0000000_101: op = opSrl;
        10'b0100000_101: op = opSra;
        10'b0000000_110: op = opOr;
        10'b0000000_111: op = opAnd;
        10'b0010000_010: op = opSh1add;
        10'b0010000_100: op = opSh2add;
        10'b0010000_110: op = opSh3add;
        10'b0100000_111: op = opAndn;
        10'b0100000_110: op = opOrn;
        10'b0100000_100: op = opXnor;
        10'b0110000_001: op = opRol;
        10'b0110000_101: op = opRor;
        10'b0110000_011: op = opCpop;          // Spare slot next to rol, no rs2 field here
        10'b0000101_100: op = opMin;
        10'b0000101_101: op = opMinu;
        10'b0000101_110: op = opMax;
        10'b0000101_111: op = opMaxu;
        10'b0010100_001: op = opBset;
        10'b0100100_001: op = opBclr;
        10'b0110100_001: op = opBinv;
        10'b0100100_101: op = opBext;
        default:         op = opIllegal;
      endcase
    end
  end

  assign illegal = (op == opIllegal);

  //////////////////////////////////////////////////////////////////////////////
  // Control bundle
  //////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // Plain add unless an op says otherwise
    ctrl.subArith  = 1'b0;
    ctrl.invB      = 1'b0;
    ctrl.shAddAmt  = 2'd0;
    ctrl.right     = 1'b0;
    ctrl.rotate    = 1'b0;
    ctrl.resultSel = selSum;
    ctrl.bmOp      = bmMin;
    case (op)
      opSub: ctrl.subArith = 1'b1;
      opSh1add, opSh2add, opSh3add: ctrl.shAddAmt = funct3[2:1];  // 010/100/110 give 1/2/3
      opSll, opSrl, opSra, opRol, opRor: begin
        ctrl.resultSel = selShift;
        ctrl.right     = funct3[2];            // 101 is right, 001 is left
        ctrl.subArith  = (op == opSra);
        ctrl.rotate    = (op == opRol) || (op == opRor);
      end
      opSlt, opSltu: begin
        ctrl.subArith  = 1'b1;                 // Flags come from a - b
        ctrl.resultSel = (op == opSlt) ? selSlt : selSltu;
      end
      opXor, opXnor: begin
        ctrl.resultSel = selXor;
        ctrl.invB      = (op == opXnor);
      end
      opOr, opOrn: begin
        ctrl.resultSel = selOr;
        ctrl.invB      = (op == opOrn);
      end
      opAnd, opAndn: begin
        ctrl.resultSel = selAnd;
        ctrl.invB      = (op == opAndn);
      end
      opMin, opMax, opMinu, opMaxu: begin
        ctrl.subArith  = 1'b1;                 // Min/max reuse the adder compare
        ctrl.resultSel = selBitManip;
      end
      opCpop, opBset, opBclr, opBinv, opBext: ctrl.resultSel = selBitManip;
      default: ;                               // add and illegal keep the defaults
    endcase

    // Sub-op for the bit-manipulation unit
    case (op)
      opMax:   ctrl.bmOp = bmMax;
      opMinu:  ctrl.bmOp = bmMinu;
      opMaxu:  ctrl.bmOp = bmMaxu;
      opCpop:  ctrl.bmOp = bmCpop;
      opBset:  ctrl.bmOp = bmBset;
      opBclr:  ctrl.bmOp = bmBclr;
      opBinv:  ctrl.bmOp = bmBinv;
      opBext:  ctrl.bmOp = bmBext;
      default: ctrl.bmOp = bmMin;
    endcase
  end

endmodule

// File: design/shifter.sv
`timescale 1ns/1ns

module shifter import aluPkg::*; (
  input  logic [XLEN-1:0]    a,
  input  logic [SHAMT_W-1:0] amt,
  input  logic               right,   // 1 for srl, sra, ror
  input  logic               arith,   // Sign fill on right shift
  input  logic               rotate,
  output logic [XLEN-1:0]    y
);

  logic [XLEN-1:0]   src;      // Operand, mirrored for left shifts
  logic [XLEN-1:0]   fill;     // Upper half of the funnel
  logic [2*XLEN-1:0] funnel;
  logic [XLEN-1:0]   shifted;

  // Mirror a word end for end
  function automatic logic [XLEN-1:0] bitRev(input logic [XLEN-1:0] x);
    logic [XLEN-1:0] r;
    for (int i = 0; i < XLEN; i++)
      r[i] = x[XLEN-1-i];
    return r;
  endfunction

  // Left shift is a right shift of the mirrored word
  assign src = right ? a : bitRev(a);

  always_comb begin
    if (rotate)     fill = src;                  // Wrap the word around
    else if (arith) fill = {XLEN{src[XLEN-1]}};  // Sign extension
    else            fill = '0;
  end

  assign funnel  = {fill, src} >> amt;          // One right funnel for all cases
  assign shifted = funnel[XLEN-1:0];
  assign y       = right ? shifted : bitRev(shifted);  // Undo the mirror

endmodule

// File: design/bitManipUnit.sv
`timescale 1ns/1ns

module bitManipUnit import aluPkg::*; (
  input  logic [XLEN-1:0] a,
  input  logic [XLEN-1:0] b,
  input  bitManipOpE      op,
  input  logic            lt,    // Signed a < b from the ALU adder
  input  logic            ltu,   // Unsigned a < b from the ALU adder
  output logic [XLEN-1:0] y
);

  logic [SHAMT_W-1:0] idx;      // Bit index, b modulo XLEN
  logic [XLEN-1:0]    bitMask;  // One-hot at idx
  logic [CNT_W-1:0]   popCnt;

  assign idx     = b[SHAMT_W-1:0];
  assign bitMask = {{(XLEN-1){1'b0}}, 1'b1} << idx;

  //////////////////////////////////////////////////////////////////////////////
  // Population count
  //////////////////////////////////////////////////////////////////////////////

  always_comb begin
    popCnt = '0;
    for (int i = 0; i < XLEN; i++)
      popCnt = popCnt + CNT_W'(a[i]);
  end

  //////////////////////////////////////////////////////////////////////////////
  // Result select
  //////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (op)
      // No comparator here, the adder already did a - b
      bmMin:   y = lt  ? a : b;
      bmMax:   y = lt  ? b : a;
      bmMinu:  y = ltu ? a : b;
      bmMaxu:  y = ltu ? b : a;
      bmCpop:  y = {{(XLEN-CNT_W){1'b0}}, popCnt};
      bmBset:  y = a | bitMask;
      bmBclr:  y = a & ~bitMask;
      bmBinv:  y = a ^ bitMask;
      bmBext:  y = {{(XLEN-1){1'b0}}, a[idx]};   // Single bit to lsb
      default: y = '0;                            // Unused codes
    endcase
  end

endmodule

// File: design/alu.sv
`timescale 1ns/1ns

module alu import aluPkg::*; (
  input  logic [XLEN-1:0] a,
  input  logic [XLEN-1:0] b,
  input  aluCtrlT         ctrl,
  output logic [XLEN-1:0] result,
  output logic [XLEN-1:0] sum      // Raw adder output for address users
);

  logic [XLEN-1:0] condShiftA;  // A after the shNadd pre-shift
  logic [XLEN-1:0] condInvB;    // ~B on subtract or inverted logic
  logic [XLEN-1:0] shiftOut;
  logic [XLEN-1:0] bmOut;
  logic            carry;       // Adder carry-out
  logic            neg;         // Sign of the sum
  logic            aSign;
  logic            bSign;
  logic            lt;
  logic            ltu;

  //////////////////////////////////////////////////////////////////////////////
  // Shared adder
  //////////////////////////////////////////////////////////////////////////////

  assign condShiftA = a << ctrl.shAddAmt;                   // 0 for everything but shNadd
  assign condInvB   = (ctrl.subArith | ctrl.invB) ? ~b : b;

  // Carry-in completes the two's complement on subtract
  assign {carry, sum} = {1'b0, condShiftA} + {1'b0, condInvB}
                      + (XLEN+1)'(ctrl.subArith);

  // Compare flags, valid when the sum is a - b
  assign neg   = sum[XLEN-1];
  assign aSign = a[XLEN-1];
  assign bSign = b[XLEN-1];
  assign lt    = (aSign ^ bSign) ? aSign : neg;  // Signs differ, A's sign decides
  assign ltu   = ~carry;                         // Borrow out of a - b

  // Shifts and rotates, amount from the low bits of b
  shifter shifter_i (
    .a      (a),
    .amt    (b[SHAMT_W-1:0]),
    .right  (ctrl.right),
    .arith  (ctrl.subArith),
    .rotate (ctrl.rotate),
    .y      (shiftOut)
  );

  // Zbb min/max/cpop and Zbs single-bit ops
  bitManipUnit bitManipUnit_i (
    .a   (a),
    .b   (b),
    .op  (ctrl.bmOp),
    .lt  (lt),
    .ltu (ltu),
    .y   (bmOut)
  );

  //////////////////////////////////////////////////////////////////////////////
  // Result mux
  //////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (ctrl.resultSel)
      selSum:      result = sum;                        // add, sub, shNadd
      selShift:    result = shiftOut;
      selSlt:      result = {{(XLEN-1){1'b0}}, lt};
      selSltu:     result = {{(XLEN-1){1'b0}}, ltu};
      selXor:      result = a ^ condInvB;               // xor, xnor
      selOr:       result = a | condInvB;               // or, orn
      selAnd:      result = a & condInvB;               // and, andn
      selBitManip: result = bmOut;
      default:     result = sum;
    endcase
  end

endmodule

// File: design/executeStage.sv
`timescale 1ns/1ns

module executeStage import aluPkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    reqValid,
  output logic    reqReady,
  input  execReqT req,
  output logic    rspValid,
  input  logic    rspReady,
  output execRspT rsp
);

  // Decoded request held between the two stages
  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic             illegal;
    aluCtrlT          ctrl;
    logic [XLEN-1:0]  a;
    logic [XLEN-1:0]  b;
  } stage1T;

  aluCtrlT         decCtrl;     // Decoder output for the incoming request
  logic            decIllegal;
  stage1T          s1Next;      // Stage-1 load value
  stage1T          s1;          // Stage-1 payload
  logic            s1Valid;
  logic            s1Ready;     // Stage 1 can take a request this cycle
  logic            s2Ready;     // Response register can take stage 1
  logic [XLEN-1:0] aluResult;

  //////////////////////////////////////////////////////////////////////////////
  // Stage 1, decode
  //////////////////////////////////////////////////////////////////////////////

  aluDecoder aluDecoder_i (
    .aluOp   (req.aluOp),
    .funct7  (req.funct7),
    .funct3  (req.funct3),
    .ctrl    (decCtrl),
    .illegal (decIllegal)
  );

  always_comb begin
    s1Next.tag     = req.tag;
    s1Next.illegal = decIllegal;
    s1Next.ctrl    = decCtrl;
    s1Next.a       = req.a;
    s1Next.b       = req.b;
  end

  // Ready when empty or draining into stage 2 this cycle
  assign s2Ready  = ~rspValid | rspReady;
  assign s1Ready  = ~s1Valid | s2Ready;
  assign reqReady = s1Ready;

  //////////////////////////////////////////////////////////////////////////////
  // Stage 2, execute
  //////////////////////////////////////////////////////////////////////////////

  alu alu_i (
    .a      (s1.a),
    .b      (s1.b),
    .ctrl   (s1.ctrl),
    .result (aluResult),
    .sum    ()              // Address path user only
  );

  // Valid bits
  always_ff @(posedge clk) begin
    if (rst) begin
      s1Valid  <= 1'b0;
      rspValid <= 1'b0;
    end else begin
      if (s1Ready) s1Valid  <= reqValid;
      if (s2Ready) rspValid <= s1Valid;   // Holds under back-pressure
    end
  end

  // Payload moves only on a transfer
  always_ff @(posedge clk) begin
    if (reqValid && s1Ready) s1 <= s1Next;
    if (s1Valid && s2Ready) begin
      rsp.tag     <= s1.tag;
      rsp.illegal <= s1.illegal;
      rsp.result  <= s1.illegal ? '0 : aluResult;  // Unknown encoding returns zero
    end
  end

endmodule

// File: tb/executeStage_props.sv
`timescale 1ns/1ns

module executeStageProps import aluPkg::*; (
  input logic    clk,
  input logic    rst,
  input logic    reqValid,
  input logic    reqReady,
  input execReqT req,
  input logic    rspValid,
  input logic    rspReady,
  input execRspT rsp
);

  // Source side holds its request until taken
  reqStable: assert property (@(posedge clk) disable iff (rst)
    reqValid && !reqReady |=> reqValid && $stable(req))
    else $error("request changed before it was accepted");

  // Stalled response stays put
  rspStable: assert property (@(posedge clk) disable iff (rst)
    rspValid && !rspReady |=> rspValid && $stable(rsp))
    else $error("response changed while stalled");

  resetClears: assert property (@(posedge clk) rst |=> !rspValid)
    else $error("rspValid high after reset");

endmodule

bind executeStage executeStageProps props_i (
  .clk      (clk),
  .rst      (rst),
  .reqValid (reqValid),
  .reqReady (reqReady),
  .req      (req),
  .rspValid (rspValid),
  .rspReady (rspReady),
  .rsp      (rsp)
);

// File: tb/executeTb.sv
`timescale 1ns/1ns

module executeTb import aluPkg::*; ();

  // Request count of all tests for the watchdog
  localparam int NUM_REQ = 650 + 244 + 160 + 30 + 20 + 30;

  logic    clk = 1'b0;
  logic    rst;
  logic    reqValid;
  logic    reqReady;
  execReqT req;
  logic    rspValid;
  logic    rspReady;
  execRspT rsp;

  logic [31:0]      lcgState = 32'h46b3;
  logic [TAG_W-1:0] nextTag = '0;
  execRspT          pendingExp;        // Expected response of the request on the bus
  execRspT          expQ[$];           // Items in flight by age
  int               accQ[$];           // Acceptance cycle of each item in flight
  int               cycle = 0;
  bit               strictLatency = 1'b1;  // rspReady held high
  string            curTest = "reset";
  int               errMismatch = 0;
  int               errOther = 0;

  executeStage dut_i (
    .clk      (clk),
    .rst      (rst),
    .reqValid (reqValid),
    .reqReady (reqReady),
    .req      (req),
    .rspValid (rspValid),
    .rspReady (rspReady),
    .rsp      (rsp)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  //////////////////////////////////////////////////////////////////////////
  // Reference model from the ISA definitions
  //////////////////////////////////////////////////////////////////////////

  function automatic logic [9:0] encodeOp(aluOpE op);  // {funct7, funct3}
    case (op)
      opAdd:    return 10'b0000000_000;
      opSub:    return 10'b0100000_000;
      opSll:    return 10'b0000000_001;
      opSlt:    return 10'b0000000_010;
      opSltu:   return 10'b0000000_011;
      opXor:    return 10'b0000000_100;
      opSrl:    return 10'b0000000_101;
      opSra:    return 10'b0100000_101;
      opOr:     return 10'b0000000_110;
      opAnd:    return 10'b0000000_111;
      opSh1add: return 10'b0010000_010;
      opSh2add: return 10'b0010000_100;
      opSh3add: return 10'b0010000_110;
      opAndn:   return 10'b0100000_111;
      opOrn:    return 10'b0100000_110;
      opXnor:   return 10'b0100000_100;
      opRol:    return 10'b0110000_001;
      opRor:    return 10'b0110000_101;
      opCpop:   return 10'b0110000_011;
      opMin:    return 10'b0000101_100;
      opMinu:   return 10'b0000101_101;
      opMax:    return 10'b0000101_110;
      opMaxu:   return 10'b0000101_111;
      opBset:   return 10'b0010100_001;
      opBclr:   return 10'b0100100_001;
      opBinv:   return 10'b0110100_001;
      opBext:   return 10'b0100100_101;
      default:  return 10'b1111111_111;  // No such encoding
    endcase
  endfunction

  function automatic execRspT expectRsp(aluOpE op, execReqT r);
    execRspT         e;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [4:0]      sh;
    a = r.a;
    b = r.b;
    sh = b[4:0];  // Shift amount or bit index
    e.tag = r.tag;
    e.illegal = (op == opIllegal);
    case (op)
      opAdd:    e.result = a + b;
      opSub:    e.result = a - b;
      opSll:    e.result = a << sh;
      opSlt:    e.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      opSltu:   e.result = (a < b) ? 32'd1 : 32'd0;
      opXor:    e.result = a ^ b;
      opSrl:    e.result = a >> sh;
      opSra:    e.result = $signed(a) >>> sh;
      opOr:     e.result = a | b;
      opAnd:    e.result = a & b;
      opSh1add: e.result = (a << 1) + b;
      opSh2add: e.result = (a << 2) + b;
      opSh3add: e.result = (a << 3) + b;
      opAndn:   e.result = a & ~b;
      opOrn:    e.result = a | ~b;
      opXnor:   e.result = ~(a ^ b);
      opRol:    e.result = (a << sh) | (a >> (XLEN - sh));  // sh of 0 gives a
      opRor:    e.result = (a >> sh) | (a << (XLEN - sh));
      opMin:    e.result = ($signed(a) < $signed(b)) ? a : b;
      opMax:    e.result = ($signed(a) < $signed(b)) ? b : a;
      opMinu:   e.result = (a < b) ? a : b;
      opMaxu:   e.result = (a < b) ? b : a;
      opCpop:   e.result = $countones(a);
      opBset:   e.result = a | (32'd1 << sh);
      opBclr:   e.result = a & ~(32'd1 << sh);
      opBinv:   e.result = a ^ (32'd1 << sh);
      opBext:   e.result = (a >> sh) & 32'd1;
      default:  e.result = '0;  // Illegal returns zero
    endcase
    return e;
  endfunction

  //////////////////////////////////////////////////////////////////////////
  // Checks and response monitor
  //////////////////////////////////////////////////////////////////////////

  task automatic checkRsp(execRspT exp, execRspT act);
    if (act !== exp) begin
      errMismatch++;
      $display("MISMATCH %s: expected tag %0d ill %0b res %h, actual tag %0d ill %0b res %h",
               curTest, exp.tag, exp.illegal, exp.result, act.tag, act.illegal, act.result);
    end
  endtask

  task automatic checkFlag(string name, logic exp, logic act);
    if (act !== exp) begin
      errMismatch++;
      $display("MISMATCH %s: %s expected %b, actual %b", curTest, name, exp, act);
    end
  endtask

  task automatic checkLatency(int accCycle);
    if (strictLatency && (cycle - accCycle != 2)) begin
      errOther++;
      $display("Test %s: response came %0d cycles after acceptance instead of 2",
               curTest, cycle - accCycle);
    end
  endtask

  // Sees the values from just before the edge
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (!rst) begin
      checkFlag("reqReady", !(expQ.size() == 2 && !rspReady), reqReady);  // Low only when full
      if (rspValid && rspReady) begin
        if (expQ.size() == 0) begin
          errOther++;
          $display("Test %s: response with tag %0d arrived with nothing in flight",
                   curTest, rsp.tag);
        end else begin
          checkRsp(expQ.pop_front(), rsp);
          checkLatency(accQ.pop_front());
        end
      end
      if (reqValid && reqReady) begin
        expQ.push_back(pendingExp);
        accQ.push_back(cycle);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Drivers
  //////////////////////////////////////////////////////////////////////////

  task automatic issueRaw(aluOpE refOp, logic aluOp, logic [6:0] f7, logic [2:0] f3,
                          logic [XLEN-1:0] a, logic [XLEN-1:0] b);
    execReqT r;
    r.tag = nextTag;
    r.aluOp = aluOp;
    r.funct7 = f7;
    r.funct3 = f3;
    r.a = a;
    r.b = b;
    nextTag = nextTag + 1'b1;
    req <= r;
    pendingExp <= expectRsp(refOp, r);
    reqValid <= 1'b1;
    do @(posedge clk); while (!reqReady);  // Held until the transfer edge
  endtask

  task automatic issue(aluOpE op, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
    logic [9:0] enc;
    enc = encodeOp(op);
    issueRaw(op, 1'b1, enc[9:3], enc[2:0], a, b);
  endtask

  task automatic drain();
    reqValid <= 1'b0;
    while (expQ.size() != 0) @(posedge clk);
    @(posedge clk);
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////////

  task automatic testBaseOps();
    aluOpE           ops[10] = '{opAdd, opSub, opSll, opSlt, opSltu,
                                 opXor, opSrl, opSra, opOr, opAnd};
    logic [XLEN-1:0] corner[5] = '{32'h0, 32'h1, 32'h7fffffff, 32'h80000000, 32'hffffffff};
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    curTest = "baseOps";
    foreach (ops[i]) begin
      for (int n = 0; n < 40; n++) begin
        a = lcgNext();
        b = lcgNext();
        issue(ops[i], a, b);
      end
      foreach (corner[j])
        foreach (corner[k])
          issue(ops[i], corner[j], corner[k]);  // Sign pairs for slt vs sltu
    end
    drain();
  endtask

  task automatic testZbaZbb();
    aluOpE           ops[11] = '{opSh1add, opSh2add, opSh3add, opAndn, opOrn, opXnor,
                                 opMin, opMax, opMinu, opMaxu, opCpop};
    logic [4:0]      amts[3] = '{5'd0, 5'd1, 5'd31};
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    curTest = "zbaZbb";
    foreach (ops[i])
      for (int n = 0; n < 20; n++) begin
        a = lcgNext();
        b = lcgNext();
        issue(ops[i], a, b);
      end
    foreach (amts[j])
      for (int n = 0; n < 4; n++) begin
        a = lcgNext();
        b = (lcgNext() & ~32'h1f) | amts[j];  // Upper bits must be ignored
        issue(opRol, a, b);
        issue(opRor, a, b);
      end
    drain();
  endtask

  task automatic testZbs();
    aluOpE           ops[4] = '{opBset, opBclr, opBinv, opBext};
    logic [XLEN-1:0] a;
    curTest = "zbs";
    foreach (ops[i]) begin
      for (int idx = 0; idx < 32; idx++) begin
        a = lcgNext();
        issue(ops[i], a, idx);
      end
      for (int n = 0; n < 8; n++) begin
        a = lcgNext();
        issue(ops[i], a, lcgNext() | 32'h20);  // Index wraps modulo 32
      end
    end
    drain();
  endtask

  task automatic testAddrAndIllegal();
    logic [31:0] r;
    curTest = "addrAndIllegal";
    for (int n = 0; n < 20; n++) begin
      r = lcgNext();
      issueRaw(opAdd, 1'b0, r[30:24], r[22:20], lcgNext(), lcgNext());  // funct ignored
    end
    for (int n = 0; n < 10; n++) begin
      r = lcgNext();
      if (n < 5)
        issueRaw(opIllegal, 1'b1, {1'b1, r[29:24]}, r[22:20], lcgNext(), lcgNext());
      else
        issueRaw(opIllegal, 1'b1, 7'b0000001, r[22:20], lcgNext(), lcgNext());  // M ext
    end
    drain();
  endtask

  task automatic testThroughput();
    int startCyc;
    curTest = "throughput";
    for (int n = 0; n < 20; n++) begin
      issue(aluOpE'(n % 27), lcgNext(), lcgNext());
      if (n == 0)
        startCyc = cycle;
    end
    if (cycle - startCyc != 19) begin
      errOther++;
      $display("Test %s: 20 requests took %0d cycles to accept instead of 20",
               curTest, cycle - startCyc + 1);
    end
    drain();
  endtask

  task automatic testBackPressure();
    aluOpE           ops[30];
    logic [XLEN-1:0] as[30];
    logic [XLEN-1:0] bs[30];
    logic [31:0]     r;
    bit              done;
    curTest = "backPressure";
    strictLatency = 1'b0;
    done = 1'b0;
    for (int n = 0; n < 30; n++) begin
      r = lcgNext();
      ops[n] = aluOpE'(r[31:16] % 27);
      as[n] = lcgNext();
      bs[n] = lcgNext();
    end
    fork
      begin
        foreach (ops[n])
          issue(ops[n], as[n], bs[n]);
        drain();
        done = 1'b1;
      end
      while (!done) begin
        @(posedge clk);
        r = lcgNext();
        rspReady <= r[20];  // Upper LCG bits are the more random ones
      end
    join
    rspReady <= 1'b1;
    @(posedge clk);
    strictLatency = 1'b1;
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Run control
  //////////////////////////////////////////////////////////////////////////

  task automatic finishRun();
    $display("Summary: %0d mismatches, %0d other errors", errMismatch, errOther);
    if (errMismatch + errOther == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  initial begin
    repeat (NUM_REQ * 20 + 100) @(posedge clk);
    errOther++;
    $display("Timeout: run did not complete within %0d cycles", NUM_REQ * 20 + 100);
    finishRun();
  end

  initial begin
    rst = 1'b1;
    reqValid = 1'b0;
    req = '0;
    pendingExp = '0;
    rspReady = 1'b1;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    checkFlag("rspValid", 1'b0, rspValid);  // Empty pipeline after reset
    checkFlag("reqReady", 1'b1, reqReady);
    testBaseOps();
    testZbaZbb();
    testZbs();
    testAddrAndIllegal();
    testThroughput();
    testBackPressure();
    finishRun();
  end

endmodule

// File: tb.f
design/aluPkg.sv
design/aluDecoder.sv
design/shifter.sv
design/bitManipUnit.sv
design/alu.sv
design/executeStage.sv
tb/executeStage_props.sv
tb/executeTb.sv
